// ==== build.f ====
+incdir+logic
logic/mems_scan_pkg.sv
logic/scan_sequencer.sv
logic/dac_channel_writer.sv
logic/scan_event_tracker.sv
logic/mems_scan_top.sv
test/mems_scan_tb.sv

// ==== test/mems_scan_tb.sv ====
`include "mems_scan_settings.svh"

module mems_scan_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_WORDS = 4096;
  localparam int TOTAL_WORDS = `MEMS_NUM_CH * 1700; // worst case over all channels
  localparam int ACK_SLACK = 10000; // long hold, pauses, flag acks
  localparam int LIMIT = (TOTAL_WORDS / `MEMS_NUM_CH + 10) * 100 + ACK_SLACK;

  logic clk = 1'b0;
  logic mems_soft_reset;
  logic [1:0] mode;
  logic pause;
  logic [1:0] fifo_done; // {frame, line}
  logic [`MEMS_NUM_CH-1:0] dac_sclk;
  logic [`MEMS_NUM_CH-1:0] dac_sync_n;
  logic [`MEMS_NUM_CH-1:0] dac_din;
  logic new_line;
  logic new_frame;
  logic reversed_frame;
  logic [1:0] flags;

  logic [31:0] lfsr_q = 32'h595c;
  logic [23:0] dec_words [`MEMS_NUM_CH][MAX_WORDS]; // decoded spi words
  int dec_cnt [`MEMS_NUM_CH] = '{default: 0};
  int cmp_n = 0; // next word to compare
  int sw_idx [4]; // first word issued under each mode setting
  logic [1:0] sw_mode [4];
  int sw_cnt = 1;
  int sweeps_done [4] = '{default: 0};
  logic [1:0] cur_mode = 2'd0;
  logic cur_dir = 1'b0;
  int sw_pos = 0; // position inside the sweep
  int sweep_len = 1;
  int exp_lines = 0;
  int exp_frames = 0;
  int line_rises = 0;
  int frame_rises = 0;
  logic exp_rev [64];
  logic rise_rev [64];
  logic [1:0] flag_d = 2'b00;
  logic [1:0] done_d = 2'b00;
  logic hold_req;
  int hold_base;
  int value_errs = 0;
  int proto_errs = 0;
  int cycles = 0;

  assign flags = {new_frame, new_line};

  always #10 clk = ~clk;

  mems_scan_top mems_scan_top_inst (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .mode                (mode),
    .pause               (pause),
    .new_line_fifo_done  (fifo_done[0]),
    .new_frame_fifo_done (fifo_done[1]),
    .dac_sclk            (dac_sclk),
    .dac_sync_n          (dac_sync_n),
    .dac_din             (dac_din),
    .new_line            (new_line),
    .new_frame           (new_frame),
    .reversed_frame      (reversed_frame)
  );

  // galois lfsr, one step per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    logic lsb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lsb = lfsr_q[0];
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lsb ? 32'h80200003 : 32'h0);
      v = (v << 1) | lsb;
    end
    return v;
  endfunction

  // raster word from the scan rules, idx counts samples inside the sweep
  function automatic logic [23:0] expected_word(input logic [1:0] m, input logic rev,
                                                input int idx, input int ch);
    int spl;
    int lines;
    int ord;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] d;
    spl = 16 << m;
    lines = 8 << m;
    ord = rev ? (lines - 1 - idx / spl) : (idx / spl); // reversed sweep runs bottom up
    x = 16'((idx % spl) * (65536 / spl));
    y = 16'(ord * (65536 / lines));
    case (ch)
      0: d = x;
      1: d = `MEMS_FULL_SCALE - x;
      2: d = y;
      default: d = `MEMS_FULL_SCALE - y;
    endcase
    if (m == 2'd3) d = 16'h8000; // parked at mid-scale
    return {`MEMS_CMD_WRITE, 4'(ch), d};
  endfunction

  // mode in force when word n was issued
  function automatic logic [1:0] mode_for_word(input int n);
    logic [1:0] m;
    m = sw_mode[0];
    for (int i = 1; i < sw_cnt; i++) begin
      if (n >= sw_idx[i]) m = sw_mode[i];
    end
    return m;
  endfunction

  // all channels quiet and both flags low for n cycles
  task automatic wait_idle(input int n);
    int quiet;
    quiet = 0;
    while (quiet < n) begin
      @(negedge clk);
      if (&dac_sync_n && !new_line && !new_frame) quiet++;
      else quiet = 0;
    end
  endtask

  task automatic switch_mode(input logic [1:0] m);
    @(posedge clk);
    #2 pause = 1'b1;
    wait_idle(10); // words in flight reach the wire
    repeat (rand_bits(8)) @(posedge clk);
    sw_idx[sw_cnt] = dec_cnt[0];
    sw_mode[sw_cnt] = m;
    sw_cnt++;
    @(posedge clk);
    #2 mode = m;
    pause = 1'b0;
  endtask

  // spi decoders, din sampled on falling sclk
  for (genvar ch = 0; ch < `MEMS_NUM_CH; ch++) begin : g_dec
    logic [23:0] sh;
    int nbits = 0;
    always @(negedge dac_sclk[ch]) begin
      if (!dac_sync_n[ch]) begin
        sh = {sh[22:0], dac_din[ch]};
        nbits++;
        if (nbits == 24 && dec_cnt[ch] < MAX_WORDS) begin
          dec_words[ch][dec_cnt[ch]] = sh;
          dec_cnt[ch]++;
          nbits = 0;
        end
      end
    end
    always @(posedge dac_sync_n[ch]) begin
      assert (nbits == 0) else begin
        proto_errs++;
        $display("channel %0d sync_n rose after %0d bits of a word", ch, nbits);
      end
    end
  end

  // fifo acks, 1 to 8 cycles after a rise, one long hold on request
  for (genvar i = 0; i < 2; i++) begin : g_ack
    always begin
      int unsigned delay;
      logic held;
      @(posedge flags[i]);
      delay = 1 + rand_bits(3);
      held = 1'b0;
      if (i == 0 && hold_req) begin
        delay = 3000 + rand_bits(10);
        hold_req = 1'b0;
        hold_base = dec_cnt[0];
        held = 1'b1;
      end
      repeat (delay) @(posedge clk);
      #2 fifo_done[i] = 1'b1;
      @(posedge clk);
      #2 fifo_done[i] = 1'b0;
      if (held) begin // rest of the line plus the credits, then the stall
        assert (dec_cnt[0] - hold_base <= 16 + `MEMS_CREDITS) else begin
          value_errs++;
          $display("CHECK FAILED flag_hold: expected <= %0d actual %0d",
                   16 + `MEMS_CREDITS, dec_cnt[0] - hold_base);
        end
      end
    end
  end

  // flag monitor, falls only after an ack
  always @(negedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (flag_d[i] && !flags[i]) begin
        assert (done_d[i]) else begin
          proto_errs++;
          $display("flag %0d dropped without a fifo acknowledgment", i);
        end
      end
    end
    if (!flag_d[0] && flags[0]) line_rises++;
    if (!flag_d[1] && flags[1]) begin
      if (frame_rises < 64) rise_rev[frame_rises] = reversed_frame;
      frame_rises++;
    end
    flag_d = flags;
    done_d = fifo_done;
  end

  // compare process, one word from every channel at a time
  always @(negedge clk) begin
    logic ready;
    logic [23:0] exp_w;
    int spl;
    string tname;
    ready = 1'b1;
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      if (dec_cnt[ch] <= cmp_n) ready = 1'b0;
    end
    if (ready) begin
      if (cmp_n >= 2 && sw_pos == 0) begin // sweep start, mode latched here
        cur_mode = mode_for_word(cmp_n);
        sweep_len = (cur_mode == 2'd3) ? 1 : (16 << cur_mode) * (8 << cur_mode);
        if (cur_mode != 2'd3 && exp_frames < 64) exp_rev[exp_frames] = cur_dir;
        if (cur_mode != 2'd3) exp_frames++;
      end
      spl = 16 << cur_mode;
      if (cmp_n >= 2 && cur_mode != 2'd3 && sw_pos % spl == 0) exp_lines++;
      tname = (cmp_n < 2) ? "startup" : $sformatf("raster_mode%0d", cur_mode);
      for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
        if (cmp_n == 0) exp_w = {`MEMS_CMD_RESET, 4'(ch), 16'h0000};
        else if (cmp_n == 1) exp_w = {`MEMS_CMD_VREF, 4'(ch), `MEMS_VREF_ON};
        else exp_w = expected_word(cur_mode, cur_dir, sw_pos, ch);
        assert (dec_words[ch][cmp_n] == exp_w) else begin
          value_errs++;
          $display("CHECK FAILED %s word %0d ch %0d: expected %h actual %h",
                   tname, cmp_n, ch, exp_w, dec_words[ch][cmp_n]);
        end
      end
      if (cmp_n >= 2) begin
        sw_pos++;
        if (sw_pos == sweep_len) begin // turn around
          sw_pos = 0;
          sweeps_done[cur_mode]++;
          cur_dir = !cur_dir;
        end
      end
      cmp_n++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run passed the limit of %0d cycles", LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    mems_soft_reset = 1'b1;
    mode = 2'd0;
    pause = 1'b0;
    fifo_done = 2'b00;
    hold_req = 1'b0;
    hold_base = 0;
    sw_idx[0] = 0;
    sw_mode[0] = 2'd0;
    repeat (10) @(posedge clk);
    #2 mems_soft_reset = 1'b0;
    wait (sweeps_done[0] >= 2); // first frame done
    hold_req = 1'b1;
    wait (sweeps_done[0] >= 4); // two frames
    switch_mode(2'd1);
    wait (sweeps_done[1] >= 1);
    switch_mode(2'd3);
    wait (sweeps_done[3] >= 16);
    @(posedge clk);
    #2 pause = 1'b1;
    wait_idle(20);
    // every decoded line start and sweep start raised its flag once
    assert (line_rises == exp_lines) else begin
      value_errs++;
      $display("CHECK FAILED new_line_count: expected %0d actual %0d", exp_lines, line_rises);
    end
    assert (frame_rises == exp_frames) else begin
      value_errs++;
      $display("CHECK FAILED new_frame_count: expected %0d actual %0d", exp_frames, frame_rises);
    end
    for (int i = 0; i < frame_rises && i < exp_frames && i < 64; i++) begin
      assert (rise_rev[i] == exp_rev[i]) else begin
        value_errs++;
        $display("CHECK FAILED reversed_frame %0d: expected %0b actual %0b",
                 i, exp_rev[i], rise_rev[i]);
      end
    end
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      assert (dec_cnt[ch] == cmp_n) else begin
        proto_errs++;
        $display("channel %0d decoded %0d words while %0d were compared", ch, dec_cnt[ch], cmp_n);
      end
    end
    $display("errors: value %0d, protocol %0d, words %0d", value_errs, proto_errs, cmp_n);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== logic/mems_scan_top.sv ====
`include "mems_scan_settings.svh"

module mems_scan_top (
  input  logic                      clk,
  input  logic                      mems_soft_reset,
  input  mems_scan_pkg::scan_mode_t mode,
  input  logic                      pause,
  input  logic                      new_line_fifo_done,
  input  logic                      new_frame_fifo_done,
  output logic [`MEMS_NUM_CH-1:0]   dac_sclk,
  output logic [`MEMS_NUM_CH-1:0]   dac_sync_n,
  output logic [`MEMS_NUM_CH-1:0]   dac_din,
  output logic                      new_line,
  output logic                      new_frame,
  output logic                      reversed_frame
);

  logic                      issue; // one strobe for all channels
  logic                      credit_return;
  mems_scan_pkg::dac_word_t  issue_word [`MEMS_NUM_CH];
  mems_scan_pkg::scan_mark_t issue_mark;
  logic [`MEMS_NUM_CH-1:0]   word_done;

  scan_sequencer scan_sequencer_inst (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .mode            (mode),
    .pause           (pause),
    .credit_return   (credit_return),
    .issue           (issue),
    .issue_word      (issue_word),
    .issue_mark      (issue_mark)
  );

  // channels run in lockstep off the shared issue strobe
  for (genvar ch = 0; ch < `MEMS_NUM_CH; ch++) begin : g_writer
    dac_channel_writer dac_channel_writer_inst (
      .clk             (clk),
      .mems_soft_reset (mems_soft_reset),
      .issue           (issue),
      .issue_word      (issue_word[ch]), // address nibble already set per channel
      .dac_sclk        (dac_sclk[ch]),
      .dac_sync_n      (dac_sync_n[ch]),
      .dac_din         (dac_din[ch]),
      .word_done       (word_done[ch])
    );
  end

  scan_event_tracker scan_event_tracker_inst (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .issue               (issue),
    .issue_mark          (issue_mark),
    .word_done           (word_done),
    .new_line_fifo_done  (new_line_fifo_done),
    .new_frame_fifo_done (new_frame_fifo_done),
    .credit_return       (credit_return),
    .new_line            (new_line),
    .new_frame           (new_frame),
    .reversed_frame      (reversed_frame)
  );

endmodule

// ==== logic/scan_event_tracker.sv ====
`include "mems_scan_settings.svh"

module scan_event_tracker (
  input  logic                      clk,
  input  logic                      mems_soft_reset,
  input  logic                      issue,
  input  mems_scan_pkg::scan_mark_t issue_mark,
  input  logic [`MEMS_NUM_CH-1:0]   word_done,
  input  logic                      new_line_fifo_done,
  input  logic                      new_frame_fifo_done,
  output logic                      credit_return,
  output logic                      new_line,
  output logic                      new_frame,
  output logic                      reversed_frame
);

  localparam int DEPTH = `MEMS_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mems_scan_pkg::scan_mark_t mark_mem [DEPTH]; // markers in issue order
  mems_scan_pkg::scan_mark_t head;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   mark_cnt_q; // issued, not yet retired
  logic [PTR_W:0]   done_cnt_q [`MEMS_NUM_CH]; // finished on that channel, not retired
  logic             all_done;
  logic             blocked;
  logic             retire;

  always_comb begin
    all_done = 1'b1;
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      if (done_cnt_q[ch] == '0) all_done = 1'b0;
    end
  end

  assign head = mark_mem[rd_ptr_q];

  // a marked word waits until downstream has taken the previous event
  assign blocked = (head[`MEMS_MARK_LINE] && new_line) ||
                   (head[`MEMS_MARK_FRAME] && new_frame);
  assign retire  = (mark_cnt_q != '0) && all_done && !blocked;

  always_ff @(posedge clk) begin
    if (issue) mark_mem[wr_ptr_q] <= issue_mark;
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      mark_cnt_q     <= '0;
      credit_return  <= 1'b0;
      new_line       <= 1'b0;
      new_frame      <= 1'b0;
      reversed_frame <= 1'b0;
      for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
        done_cnt_q[ch] <= '0;
      end
    end else begin
      credit_return <= retire; // same edge as the flag rise
      if (issue) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (retire) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({issue, retire})
        2'b10:   mark_cnt_q <= mark_cnt_q + 1'b1;
        2'b01:   mark_cnt_q <= mark_cnt_q - 1'b1;
        default: mark_cnt_q <= mark_cnt_q;
      endcase
      for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
        case ({word_done[ch], retire})
          2'b10:   done_cnt_q[ch] <= done_cnt_q[ch] + 1'b1;
          2'b01:   done_cnt_q[ch] <= done_cnt_q[ch] - 1'b1;
          default: done_cnt_q[ch] <= done_cnt_q[ch];
        endcase
      end
      if (retire && head[`MEMS_MARK_LINE]) begin
        new_line <= 1'b1;
      end else if (new_line_fifo_done) begin
        new_line <= 1'b0;
      end
      if (retire && head[`MEMS_MARK_FRAME]) begin
        new_frame      <= 1'b1;
        reversed_frame <= head[`MEMS_MARK_REV]; // level holds for the whole sweep
      end else if (new_frame_fifo_done) begin
        new_frame <= 1'b0;
      end
    end
  end

  // a writer may only finish words the sequencer handed it
  for (genvar ch = 0; ch < `MEMS_NUM_CH; ch++) begin : g_done_chk
    a_done_outstanding : assert property (@(posedge clk) disable iff (mems_soft_reset)
      word_done[ch] |-> (done_cnt_q[ch] < mark_cnt_q));
  end

endmodule

// ==== logic/dac_channel_writer.sv ====
`include "mems_scan_settings.svh"

module dac_channel_writer (
  input  logic                     clk,
  input  logic                     mems_soft_reset,
  input  logic                     issue,
  input  mems_scan_pkg::dac_word_t issue_word,
  output logic                     dac_sclk,
  output logic                     dac_sync_n,
  output logic                     dac_din,
  output logic                     word_done
);

  localparam int DEPTH = `MEMS_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int DIV_W = $clog2(`MEMS_SPI_DIV + 1);
  localparam int BIT_W = $clog2(`MEMS_WORD_BITS);
  localparam int MSB = `MEMS_WORD_BITS - 1;

  mems_scan_pkg::dac_word_t   fifo_mem [DEPTH];
  mems_scan_pkg::dac_word_t   shift_q; // word on the wire
  mems_scan_pkg::spi_state_t  state_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic [DIV_W-1:0] div_q; // position inside the sclk half-period
  logic [BIT_W-1:0] bit_q; // bits already sent
  logic             pop;
  logic             half_end;
  logic             last_bit;

  assign pop      = (state_q == mems_scan_pkg::spi_idle) && (count_q != '0);
  assign half_end = (div_q == DIV_W'(`MEMS_SPI_DIV - 1));
  assign last_bit = (bit_q == BIT_W'(MSB));

  always_ff @(posedge clk) begin
    if (issue) fifo_mem[wr_ptr_q] <= issue_word;
    if (pop) begin
      shift_q <= fifo_mem[rd_ptr_q];
    end else if ((state_q == mems_scan_pkg::spi_shift) && half_end && !dac_sclk) begin
      shift_q <= shift_q << 1; // next bit follows the rising edge
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state_q    <= mems_scan_pkg::spi_idle;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      div_q      <= '0;
      bit_q      <= '0;
      dac_sclk   <= 1'b1; // sclk idles high
      dac_sync_n <= 1'b1;
      dac_din    <= 1'b0;
      word_done  <= 1'b0;
    end else begin
      word_done <= 1'b0;
      if (issue) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({issue, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      case (state_q)
        mems_scan_pkg::spi_idle: begin
          if (pop) begin // frame opens with the msb already on din
            dac_sync_n <= 1'b0;
            dac_din    <= fifo_mem[rd_ptr_q][MSB];
            div_q      <= '0;
            bit_q      <= '0;
            state_q    <= mems_scan_pkg::spi_shift;
          end
        end
        mems_scan_pkg::spi_shift: begin
          if (half_end) begin
            div_q <= '0;
            if (dac_sclk) begin
              dac_sclk  <= 1'b0; // dac samples here
              word_done <= last_bit;
            end else begin
              dac_sclk <= 1'b1;
              if (last_bit) begin
                dac_sync_n <= 1'b1;
                dac_din    <= 1'b0;
                state_q    <= mems_scan_pkg::spi_gap;
              end else begin
                dac_din <= shift_q[MSB-1];
                bit_q   <= bit_q + 1'b1;
              end
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        // gap cycle plus the idle cycle give two cycles of sync high
        default: state_q <= mems_scan_pkg::spi_idle;
      endcase
    end
  end

  // holds as long as the sequencer respects its credits
  a_queue_no_overflow : assert property (@(posedge clk) disable iff (mems_soft_reset)
    issue |-> ((count_q != (PTR_W + 1)'(DEPTH)) || pop));

endmodule

// ==== logic/scan_sequencer.sv ====
`include "mems_scan_settings.svh"

module scan_sequencer (
  input  logic                      clk,
  input  logic                      mems_soft_reset,
  input  mems_scan_pkg::scan_mode_t mode,
  input  logic                      pause,
  input  logic                      credit_return,
  output logic                      issue,
  output mems_scan_pkg::dac_word_t  issue_word [`MEMS_NUM_CH],
  output mems_scan_pkg::scan_mark_t issue_mark
);

  mems_scan_pkg::seq_state_t  state_q;
  mems_scan_pkg::credit_t     credit_q; // free slots shared by all channels
  mems_scan_pkg::scan_mode_t  mode_q; // mode of the running sweep
  mems_scan_pkg::scan_mode_t  eff_mode;
  mems_scan_pkg::dac_sample_t x_code;
  mems_scan_pkg::dac_sample_t y_code;
  logic [5:0] samp_q; // up to 64 samples per line
  logic [5:0] samp_last;
  logic [4:0] line_q; // up to 32 lines
  logic [4:0] line_last;
  logic [4:0] line_ord; // line as seen by the mirror
  logic       dir_q; // 1 on the reversed sweep
  logic       sweep_start;
  logic       park;

  // mode only changes between sweeps
  always_comb begin
    sweep_start = (samp_q == '0) && (line_q == '0);
    eff_mode    = sweep_start ? mode : mode_q;
    park        = (eff_mode == 2'd3);
    case (eff_mode)
      2'd0: begin
        samp_last = 6'd15;
        line_last = 5'd7;
      end
      2'd1: begin
        samp_last = 6'd31;
        line_last = 5'd15;
      end
      2'd2: begin
        samp_last = 6'd63;
        line_last = 5'd31;
      end
      default: begin // counters stay at zero while parked
        samp_last = '0;
        line_last = '0;
      end
    endcase
    line_ord = dir_q ? (line_last - line_q) : line_q; // bottom up when reversed
    // index times 65536 / count is a plain shift
    case (eff_mode)
      2'd0: begin
        x_code = {samp_q[3:0], 12'd0};
        y_code = {line_ord[2:0], 13'd0};
      end
      2'd1: begin
        x_code = {samp_q[4:0], 11'd0};
        y_code = {line_ord[3:0], 12'd0};
      end
      2'd2: begin
        x_code = {samp_q, 10'd0};
        y_code = {line_ord, 11'd0};
      end
      default: begin
        x_code = `MEMS_MID_SCALE;
        y_code = `MEMS_MID_SCALE;
      end
    endcase
  end

  // startup commands ignore pause
  always_comb begin
    case (state_q)
      mems_scan_pkg::seq_dac_reset,
      mems_scan_pkg::seq_vref_setup: issue = (credit_q != '0);
      mems_scan_pkg::seq_scan:       issue = (credit_q != '0) && !pause;
      default:                       issue = 1'b0;
    endcase
  end

  always_comb begin
    mems_scan_pkg::dac_sample_t sample;
    issue_mark = '0;
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      sample = (ch < `MEMS_NUM_CH / 2) ? x_code : y_code; // lower half drives x
      if ((ch % 2 == 1) && !park) begin
        sample = `MEMS_FULL_SCALE - sample; // negative electrode mirrors positive
      end
      case (state_q)
        mems_scan_pkg::seq_dac_reset: begin
          issue_word[ch] = {`MEMS_CMD_RESET, `MEMS_ADDR_BITS'(ch), 16'h0000};
        end
        mems_scan_pkg::seq_vref_setup: begin
          issue_word[ch] = {`MEMS_CMD_VREF, `MEMS_ADDR_BITS'(ch), `MEMS_VREF_ON};
        end
        default: issue_word[ch] = {`MEMS_CMD_WRITE, `MEMS_ADDR_BITS'(ch), sample};
      endcase
    end
    if ((state_q == mems_scan_pkg::seq_scan) && !park) begin
      issue_mark[`MEMS_MARK_LINE]  = (samp_q == '0);
      issue_mark[`MEMS_MARK_FRAME] = sweep_start;
      issue_mark[`MEMS_MARK_REV]   = dir_q;
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state_q  <= mems_scan_pkg::seq_idle;
      credit_q <= mems_scan_pkg::credit_t'(`MEMS_CREDITS);
      mode_q   <= '0;
      samp_q   <= '0;
      line_q   <= '0;
      dir_q    <= 1'b0;
    end else begin
      case ({issue, credit_return})
        2'b10:   credit_q <= credit_q - 2'd1;
        2'b01:   credit_q <= credit_q + 2'd1;
        default: credit_q <= credit_q; // both or neither
      endcase
      case (state_q)
        mems_scan_pkg::seq_idle: state_q <= mems_scan_pkg::seq_dac_reset;
        mems_scan_pkg::seq_dac_reset: begin
          if (issue) state_q <= mems_scan_pkg::seq_vref_setup;
        end
        mems_scan_pkg::seq_vref_setup: begin
          if (issue) state_q <= mems_scan_pkg::seq_scan;
        end
        default: begin
          if (issue) begin
            mode_q <= eff_mode;
            if (samp_q == samp_last) begin
              samp_q <= '0;
              if (line_q == line_last) begin // turn around at the end of a sweep
                line_q <= '0;
                dir_q  <= ~dir_q;
              end else begin
                line_q <= line_q + 5'd1;
              end
            end else begin
              samp_q <= samp_q + 6'd1;
            end
          end
        end
      endcase
    end
  end

  a_issue_needs_credit : assert property (@(posedge clk) disable iff (mems_soft_reset)
    issue |-> (credit_q != '0));

  // the tracker hands back only what was taken
  a_credit_no_excess : assert property (@(posedge clk) disable iff (mems_soft_reset)
    credit_return |-> (credit_q != mems_scan_pkg::credit_t'(`MEMS_CREDITS)));

endmodule

// ==== logic/mems_scan_pkg.sv ====
`include "mems_scan_settings.svh"

package mems_scan_pkg;

  // raw sample code for one dac channel
  typedef logic [`MEMS_DAC_BITS-1:0] dac_sample_t;

  // {cmd[23:20], addr[19:16], data[15:0]}
  typedef logic [`MEMS_WORD_BITS-1:0] dac_word_t;

  // 0..2 raster sizes, 3 parks the mirror
  typedef logic [1:0] scan_mode_t;

  // {reversed, frame start, line start}
  typedef logic [2:0] scan_mark_t;

  typedef logic [1:0] credit_t; // 0..MEMS_CREDITS

  typedef enum logic [1:0] {
    seq_idle,
    seq_dac_reset, // reset command to all channels
    seq_vref_setup, // reference command to all channels
    seq_scan
  } seq_state_t;

  typedef enum logic [1:0] {
    spi_idle,
    spi_shift, // sync_n low, 24 sclk periods
    spi_gap
  } spi_state_t;

endpackage

// ==== logic/mems_scan_settings.svh ====
`ifndef MEMS_SCAN_SETTINGS_SVH
`define MEMS_SCAN_SETTINGS_SVH

// one dac channel per mirror electrode
`define MEMS_NUM_CH 4 // x+, x-, y+, y-

// words in flight per channel before the sequencer stalls
`define MEMS_CREDITS 2

// clk cycles per sclk half-period
`define MEMS_SPI_DIV 2

// spi word layout, sent msb first
`define MEMS_WORD_BITS 24
`define MEMS_ADDR_BITS 4 // channel address nibble
`define MEMS_DAC_BITS 16 // data field

// command nibble in bits 23:20
`define MEMS_CMD_WRITE 4'h3 // write and update one channel
`define MEMS_CMD_RESET 4'h7 // dac software reset
`define MEMS_CMD_VREF 4'h8 // reference setup

// data field values
`define MEMS_VREF_ON 16'h0001 // internal reference enabled
`define MEMS_FULL_SCALE 16'hffff
`define MEMS_MID_SCALE 16'h8000 // mirror rest position

// marker bits carried with each issued word
`define MEMS_MARK_LINE 0 // first sample of a line
`define MEMS_MARK_FRAME 1 // first sample of a sweep
`define MEMS_MARK_REV 2 // sweep runs bottom up

`endif
